// ==== verilog/scu_cfg.svh ====
`ifndef SCU_CFG_SVH
`define SCU_CFG_SVH

// System bus widths
`define SCU_ADDR_W   27
`define SCU_DATA_W   32
`define SCU_HALF_W   16

// DMA channels
`define SCU_DMA_CH   3
`define SCU_CH_W     2
`define SCU_COUNT_W  12

// Register window of 256 bytes
`define SCU_REG_BASE 27'h5FE0000
`define SCU_REG_LEN  27'h0000100

// A-bus window with inclusive bounds
`define SCU_ABUS_LO  27'h2000000
`define SCU_ABUS_HI  27'h58FFFFF

`endif

// ==== verilog/scuPkg.sv ====
`include "scu_cfg.svh"

package scuPkg;

	// Channel offsets are relative to 0x20 * channel
	typedef enum logic [7:0] {
		REG_RADDR  = 8'h00,
		REG_WADDR  = 8'h04,
		REG_COUNT  = 8'h08,
		REG_ADD    = 8'h0C,
		REG_ENABLE = 8'h10,
		REG_STATUS = 8'h7C,
		REG_MASK   = 8'hA0,
		REG_ISTAT  = 8'hA4
	} regAddr_t;

	typedef struct packed {
		logic [`SCU_ADDR_W-1:0]  readAddr;
		logic [`SCU_ADDR_W-1:0]  writeAddr;
		logic [`SCU_COUNT_W-1:0] count;
		logic                    readInc;
		logic                    writeInc;
	} dmaChanCfg_t;

	typedef enum logic [2:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE,
		DMA_DONE
	} dmaState_t;

	typedef enum logic [2:0] {
		AB_IDLE,
		AB_ADDR,
		AB_STROBE,
		AB_HIGH,
		AB_LOW
	} aBusState_t;

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_HOST,
		OWN_DMA
	} arbOwner_t;

endpackage

// ==== verilog/aBusReqIf.sv ====
`timescale 1ns/1ps
`include "scu_cfg.svh"

interface aBusReqIf;
	logic                   req;
	logic [`SCU_ADDR_W-1:0] addr;
	logic [`SCU_DATA_W-1:0] wdata;
	logic                   write;
	logic [`SCU_DATA_W-1:0] rdata;
	logic                   done;

	// Fields stay stable while req is high
	modport requester (
		output req, addr, wdata, write,
		input  rdata, done
	);

	modport arbiter (
		input  req, addr, wdata, write,
		output rdata, done
	);

	modport master (
		input  req, addr, wdata, write,
		output rdata, done
	);
endinterface

// ==== verilog/cpuPort.sv ====
`timescale 1ns/1ps
`include "scu_cfg.svh"

module cpuPort (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   pSel,
	input  logic                   pEnable,
	input  logic                   pWrite,
	input  logic [`SCU_ADDR_W-1:0] pAddr,
	input  logic [`SCU_DATA_W-1:0] pWData,
	output logic [`SCU_DATA_W-1:0] pRData,
	output logic                   pReady,
	output logic                   pSlvErr,
	aBusReqIf.requester            hostBus,
	output scuPkg::dmaChanCfg_t    chanCfg [`SCU_DMA_CH],
	output logic [`SCU_DMA_CH-1:0] start,
	input  logic [`SCU_DMA_CH-1:0] running,
	input  logic [`SCU_DMA_CH-1:0] pending,
	input  logic [`SCU_DMA_CH-1:0] chanDone,
	input  logic                   vblankN,
	output logic [3:0]             cirlN
);
	logic                   access;
	logic                   regHit;
	logic                   aBusHit;
	logic                   regWrite;
	logic [7:0]             offset;
	logic                   chanHit;
	logic [`SCU_CH_W-1:0]   chanSel;
	logic [7:0]             chanReg;
	logic [`SCU_DMA_CH-1:0] chanEn;
	logic [`SCU_DATA_W-1:0] regRData;
	logic [`SCU_DATA_W-1:0] rdHold;
	logic                   hostIssue;
	logic                   hostAck;
	logic                   vblankPrev;
	logic                   vblankFall;
	logic                   vblankInt;
	logic [`SCU_DMA_CH-1:0] dmaInt;
	logic                   vblankMask;
	logic [`SCU_DMA_CH-1:0] dmaMask;
	logic [`SCU_DATA_W-1:0] istatWord;
	logic [`SCU_DATA_W-1:0] maskWord;
	logic [3:0]             level;

	assign access   = pSel && pEnable;
	assign regHit   = pAddr >= `SCU_REG_BASE && pAddr < `SCU_REG_BASE + `SCU_REG_LEN;
	assign aBusHit  = pAddr >= `SCU_ABUS_LO && pAddr <= `SCU_ABUS_HI;
	assign regWrite = access && pWrite && regHit;
	assign offset   = pAddr[7:0];
	assign chanHit  = offset < 8'h60;
	assign chanSel  = offset[6:5];
	assign chanReg  = {3'b000, offset[4:0]};

	// DMA end bits run 11 down to 9 for channels 0 to 2
	assign istatWord = {20'd0, dmaInt[0], dmaInt[1], dmaInt[2], 8'd0, vblankInt};
	assign maskWord  = {20'd0, dmaMask[0], dmaMask[1], dmaMask[2], 8'd0, vblankMask};

	always_comb begin
		regRData = '0;
		if (chanHit) begin
			case (chanReg)
				scuPkg::REG_RADDR:  regRData = 32'(chanCfg[chanSel].readAddr);
				scuPkg::REG_WADDR:  regRData = 32'(chanCfg[chanSel].writeAddr);
				scuPkg::REG_COUNT:  regRData = 32'(chanCfg[chanSel].count);
				scuPkg::REG_ADD: begin
					regRData = {23'd0, chanCfg[chanSel].readInc, 7'd0,
						chanCfg[chanSel].writeInc};
				end
				scuPkg::REG_ENABLE: regRData = {23'd0, chanEn[chanSel], 8'd0};
				default:            regRData = '0;
			endcase
		end else begin
			case (offset)
				scuPkg::REG_STATUS: regRData = 32'({running, 1'b0, pending});
				scuPkg::REG_MASK:   regRData = maskWord;
				scuPkg::REG_ISTAT:  regRData = istatWord;
				default:            regRData = '0;
			endcase
		end
	end

	// A-bus accesses wait for the forwarded word
	assign pReady  = access && (aBusHit ? hostAck : 1'b1);
	assign pSlvErr = access && !regHit && !aBusHit;
	assign pRData  = aBusHit ? rdHold : (regHit ? regRData : '0);

	assign hostIssue = access && aBusHit && !hostBus.req && !hostAck;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			hostBus.req <= 1'b0;
			hostAck <= 1'b0;
		end else begin
			hostAck <= 1'b0;
			if (hostBus.req && hostBus.done) begin
				hostBus.req <= 1'b0;
				hostAck <= 1'b1;
			end else if (hostIssue) begin
				hostBus.req <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (hostIssue) begin
			hostBus.addr <= pAddr;
			hostBus.wdata <= pWData;
			hostBus.write <= pWrite;
		end
		if (hostBus.done) begin
			rdHold <= hostBus.rdata;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int c = 0; c < `SCU_DMA_CH; c++) begin
				chanCfg[c] <= '0;
			end
			chanEn <= '0;
			start <= '0;
			vblankMask <= 1'b0;
			dmaMask <= '0;
		end else begin
			start <= '0;
			if (regWrite && chanHit) begin
				for (int c = 0; c < `SCU_DMA_CH; c++) begin
					// Running channel keeps its settings
					if (chanSel == c && !running[c]) begin
						case (chanReg)
							scuPkg::REG_RADDR: chanCfg[c].readAddr <= pWData[`SCU_ADDR_W-1:0];
							scuPkg::REG_WADDR: chanCfg[c].writeAddr <= pWData[`SCU_ADDR_W-1:0];
							scuPkg::REG_COUNT: chanCfg[c].count <= pWData[`SCU_COUNT_W-1:0];
							scuPkg::REG_ADD: begin
								chanCfg[c].readInc <= pWData[8];
								chanCfg[c].writeInc <= pWData[0];
							end
							scuPkg::REG_ENABLE: begin
								chanEn[c] <= pWData[8];
								start[c] <= pWData[8] && pWData[0];
							end
							default: ;
						endcase
					end
				end
			end
			if (regWrite && offset == scuPkg::REG_MASK) begin
				vblankMask <= pWData[0];
				for (int c = 0; c < `SCU_DMA_CH; c++) begin
					dmaMask[c] <= pWData[11-c];
				end
			end
		end
	end

	assign vblankFall = vblankPrev && !vblankN;

	always_comb begin
		if (vblankInt && !vblankMask) begin
			level = 4'hF;
		end else if ((dmaInt[0] && !dmaMask[0]) || (dmaInt[1] && !dmaMask[1])) begin
			level = 4'h6;
		end else if (dmaInt[2] && !dmaMask[2]) begin
			level = 4'h5;
		end else begin
			level = 4'h0;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			vblankPrev <= 1'b1;
			vblankInt <= 1'b0;
			dmaInt <= '0;
			cirlN <= 4'hF;
		end else begin
			vblankPrev <= vblankN;
			// Zero bits clear, new events win
			if (regWrite && offset == scuPkg::REG_ISTAT) begin
				if (!pWData[0]) vblankInt <= 1'b0;
				for (int c = 0; c < `SCU_DMA_CH; c++) begin
					if (!pWData[11-c]) dmaInt[c] <= 1'b0;
				end
			end
			if (vblankFall) vblankInt <= 1'b1;
			for (int c = 0; c < `SCU_DMA_CH; c++) begin
				if (chanDone[c]) dmaInt[c] <= 1'b1;
			end
			cirlN <= ~level;
		end
	end
endmodule

// ==== verilog/dmaEngine.sv ====
`timescale 1ns/1ps
`include "scu_cfg.svh"

module dmaEngine (
	input  logic                   CLK,
	input  logic                   RST_N,
	aBusReqIf.requester            dmaBus,
	input  scuPkg::dmaChanCfg_t    chanCfg [`SCU_DMA_CH],
	input  logic [`SCU_DMA_CH-1:0] start,
	output logic [`SCU_DMA_CH-1:0] running,
	output logic [`SCU_DMA_CH-1:0] pending,
	output logic [`SCU_DMA_CH-1:0] chanDone
);
	scuPkg::dmaState_t       state;
	logic [`SCU_CH_W-1:0]    curCh;
	logic [`SCU_CH_W-1:0]    pickCh;
	logic [`SCU_ADDR_W-1:0]  readAddr;
	logic [`SCU_ADDR_W-1:0]  writeAddr;
	logic [`SCU_COUNT_W-1:0] remaining;
	logic                    readInc;
	logic                    writeInc;
	logic [`SCU_DATA_W-1:0]  dataWord;
	logic                    busEnd;

	// Lowest pending channel wins
	always_comb begin
		pickCh = '0;
		for (int c = `SCU_DMA_CH - 1; c >= 0; c--) begin
			if (pending[c]) pickCh = `SCU_CH_W'(c);
		end
	end

	assign busEnd = dmaBus.req && dmaBus.done;

	assign dmaBus.addr  = (state == scuPkg::DMA_WRITE) ? writeAddr : readAddr;
	assign dmaBus.write = (state == scuPkg::DMA_WRITE);
	assign dmaBus.wdata = dataWord;

	always_comb begin
		chanDone = '0;
		if (state == scuPkg::DMA_DONE) chanDone[curCh] = 1'b1;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= scuPkg::DMA_IDLE;
			curCh <= '0;
			pending <= '0;
			running <= '0;
			dmaBus.req <= 1'b0;
			readAddr <= '0;
			writeAddr <= '0;
			remaining <= '0;
			readInc <= 1'b0;
			writeInc <= 1'b0;
		end else begin
			pending <= pending | start;
			case (state)
				scuPkg::DMA_IDLE: begin
					if (|pending) begin
						pending[pickCh] <= 1'b0;
						running[pickCh] <= 1'b1;
						curCh <= pickCh;
						readAddr <= chanCfg[pickCh].readAddr;
						writeAddr <= chanCfg[pickCh].writeAddr;
						remaining <= chanCfg[pickCh].count;
						readInc <= chanCfg[pickCh].readInc;
						writeInc <= chanCfg[pickCh].writeInc;
						state <= scuPkg::DMA_READ;
					end
				end
				scuPkg::DMA_READ: begin
					if (!dmaBus.req) begin
						dmaBus.req <= 1'b1;
					end else if (busEnd) begin
						dmaBus.req <= 1'b0;
						if (readInc) readAddr <= readAddr + 27'd4;
						state <= scuPkg::DMA_WRITE;
					end
				end
				scuPkg::DMA_WRITE: begin
					if (!dmaBus.req) begin
						dmaBus.req <= 1'b1;
					end else if (busEnd) begin
						dmaBus.req <= 1'b0;
						if (writeInc) writeAddr <= writeAddr + 27'd4;
						// Count of zero wraps through 4096 words
						remaining <= remaining - 1'b1;
						state <= (remaining == 1) ? scuPkg::DMA_DONE : scuPkg::DMA_READ;
					end
				end
				scuPkg::DMA_DONE: begin
					running[curCh] <= 1'b0;
					state <= scuPkg::DMA_IDLE;
				end
				default: state <= scuPkg::DMA_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == scuPkg::DMA_READ && busEnd) dataWord <= dmaBus.rdata;
	end
endmodule

// ==== verilog/aBusArbiter.sv ====
`timescale 1ns/1ps
`include "scu_cfg.svh"

module aBusArbiter (
	input  logic        CLK,
	input  logic        RST_N,
	aBusReqIf.arbiter   hostBus,
	aBusReqIf.arbiter   dmaBus,
	aBusReqIf.requester memBus
);
	scuPkg::arbOwner_t owner;

	// Grant is held until the access completes
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			owner <= scuPkg::OWN_NONE;
		end else begin
			case (owner)
				scuPkg::OWN_NONE: begin
					if (hostBus.req) begin
						owner <= scuPkg::OWN_HOST;
					end else if (dmaBus.req) begin
						owner <= scuPkg::OWN_DMA;
					end
				end
				default: begin
					if (memBus.done) owner <= scuPkg::OWN_NONE;
				end
			endcase
		end
	end

	always_comb begin
		memBus.req = 1'b0;
		memBus.addr = hostBus.addr;
		memBus.wdata = hostBus.wdata;
		memBus.write = hostBus.write;
		case (owner)
			scuPkg::OWN_HOST: memBus.req = hostBus.req;
			scuPkg::OWN_DMA: begin
				memBus.req = dmaBus.req;
				memBus.addr = dmaBus.addr;
				memBus.wdata = dmaBus.wdata;
				memBus.write = dmaBus.write;
			end
			default: ;
		endcase
	end

	assign hostBus.done  = memBus.done && owner == scuPkg::OWN_HOST;
	assign hostBus.rdata = (owner == scuPkg::OWN_HOST) ? memBus.rdata : '0;
	assign dmaBus.done   = memBus.done && owner == scuPkg::OWN_DMA;
	assign dmaBus.rdata  = (owner == scuPkg::OWN_DMA) ? memBus.rdata : '0;
endmodule

// ==== verilog/aBusMaster.sv ====
`timescale 1ns/1ps
`include "scu_cfg.svh"

module aBusMaster (
	input  logic                   CLK,
	input  logic                   RST_N,
	aBusReqIf.master               memBus,
	output logic [`SCU_ADDR_W-2:0] aAddr,
	output logic [`SCU_HALF_W-1:0] aDataOut,
	input  logic [`SCU_HALF_W-1:0] aDataIn,
	output logic                   asN,
	output logic                   cs0N,
	output logic                   cs1N,
	output logic                   cs2N,
	output logic                   rdN,
	output logic                   wrN,
	input  logic                   awaitN
);
	scuPkg::aBusState_t     state;
	logic [`SCU_HALF_W-1:0] upperHalf;

	// Lower half comes straight from the pins on the last cycle
	assign memBus.done  = (state == scuPkg::AB_LOW) && awaitN;
	assign memBus.rdata = {upperHalf, aDataIn};

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= scuPkg::AB_IDLE;
			aAddr <= '0;
			aDataOut <= '0;
			asN <= 1'b1;
			cs0N <= 1'b1;
			cs1N <= 1'b1;
			cs2N <= 1'b1;
			rdN <= 1'b1;
			wrN <= 1'b1;
		end else begin
			case (state)
				scuPkg::AB_IDLE: begin
					if (memBus.req) begin
						aAddr <= memBus.addr[`SCU_ADDR_W-2:0];
						case (memBus.addr[26:24])
							3'b010, 3'b011: cs0N <= 1'b0;
							3'b100:         cs1N <= 1'b0;
							default:        cs2N <= 1'b0;
						endcase
						state <= scuPkg::AB_ADDR;
					end
				end
				scuPkg::AB_ADDR: begin
					asN <= 1'b0;
					state <= scuPkg::AB_STROBE;
				end
				scuPkg::AB_STROBE: begin
					asN <= 1'b1;
					rdN <= memBus.write;
					wrN <= !memBus.write;
					aDataOut <= memBus.wdata[31:16];
					state <= scuPkg::AB_HIGH;
				end
				scuPkg::AB_HIGH: begin
					if (awaitN) begin
						aDataOut <= memBus.wdata[15:0];
						state <= scuPkg::AB_LOW;
					end
				end
				scuPkg::AB_LOW: begin
					if (awaitN) begin
						rdN <= 1'b1;
						wrN <= 1'b1;
						cs0N <= 1'b1;
						cs1N <= 1'b1;
						cs2N <= 1'b1;
						state <= scuPkg::AB_IDLE;
					end
				end
				default: state <= scuPkg::AB_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (state == scuPkg::AB_HIGH && awaitN) upperHalf <= aDataIn;
	end
endmodule

// ==== verilog/scuTop.sv ====
`timescale 1ns/1ps
`include "scu_cfg.svh"

module scuTop (
	input  logic                   CLK,
	input  logic                   RST_N,
	input  logic                   pSel,
	input  logic                   pEnable,
	input  logic                   pWrite,
	input  logic [`SCU_ADDR_W-1:0] pAddr,
	input  logic [`SCU_DATA_W-1:0] pWData,
	output logic [`SCU_DATA_W-1:0] pRData,
	output logic                   pReady,
	output logic                   pSlvErr,
	output logic [`SCU_ADDR_W-2:0] aAddr,
	output logic [`SCU_HALF_W-1:0] aDataOut,
	input  logic [`SCU_HALF_W-1:0] aDataIn,
	output logic                   asN,
	output logic                   cs0N,
	output logic                   cs1N,
	output logic                   cs2N,
	output logic                   rdN,
	output logic                   wrN,
	input  logic                   awaitN,
	input  logic                   vblankN,
	output logic [3:0]             cirlN
);
	scuPkg::dmaChanCfg_t    chanCfg [`SCU_DMA_CH];
	logic [`SCU_DMA_CH-1:0] start;
	logic [`SCU_DMA_CH-1:0] running;
	logic [`SCU_DMA_CH-1:0] pending;
	logic [`SCU_DMA_CH-1:0] chanDone;

	aBusReqIf hostBus ();
	aBusReqIf dmaBus ();
	aBusReqIf memBus ();

	cpuPort uCpu (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.pSel     (pSel),
		.pEnable  (pEnable),
		.pWrite   (pWrite),
		.pAddr    (pAddr),
		.pWData   (pWData),
		.pRData   (pRData),
		.pReady   (pReady),
		.pSlvErr  (pSlvErr),
		.hostBus  (hostBus.requester),
		.chanCfg  (chanCfg),
		.start    (start),
		.running  (running),
		.pending  (pending),
		.chanDone (chanDone),
		.vblankN  (vblankN),
		.cirlN    (cirlN)
	);

	dmaEngine uDma (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.dmaBus   (dmaBus.requester),
		.chanCfg  (chanCfg),
		.start    (start),
		.running  (running),
		.pending  (pending),
		.chanDone (chanDone)
	);

	aBusArbiter uArb (
		.CLK     (CLK),
		.RST_N   (RST_N),
		.hostBus (hostBus.arbiter),
		.dmaBus  (dmaBus.arbiter),
		.memBus  (memBus.requester)
	);

	aBusMaster uMaster (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.memBus   (memBus.master),
		.aAddr    (aAddr),
		.aDataOut (aDataOut),
		.aDataIn  (aDataIn),
		.asN      (asN),
		.cs0N     (cs0N),
		.cs1N     (cs1N),
		.cs2N     (cs2N),
		.rdN      (rdN),
		.wrN      (wrN),
		.awaitN   (awaitN)
	);
endmodule

// ==== tests/aBusMem.sv ====
`timescale 1ns/1ps

module aBusMem (
	input  logic        CLK,
	input  logic        RST_N,
	input  logic [25:0] aAddr,
	input  logic [15:0] aDataOut,
	output logic [15:0] aDataIn,
	input  logic        asN,
	input  logic        rdN,
	input  logic        wrN,
	output logic        awaitN
);
	logic [31:0] mem [logic [23:0]];
	logic        active;
	logic        lowHalf;
	logic [23:0] wordAddr;
	logic [31:0] word;
	int          waitLeft;
	logic        nextAwait;
	logic [15:0] nextData;

	// Untouched words still differ for every address
	function automatic logic [31:0] fillWord(input logic [23:0] a);
		return {a[11:0], a[23:12], 8'h5A} ^ {8'hC3, a};
	endfunction

	function automatic logic [31:0] readMem(input logic [23:0] a);
		if (mem.exists(a)) begin
			return mem[a];
		end
		return fillWord(a);
	endfunction

	initial begin
		aDataIn = '0;
		awaitN = 1'b1;
		active = 1'b0;
		lowHalf = 1'b0;
		wordAddr = '0;
		waitLeft = 0;
	end

	// Decide mid-cycle, drive just after the next rising edge
	always begin
		@(negedge CLK);
		nextAwait = 1'b1;
		nextData = aDataIn;
		if (!RST_N) begin
			active = 1'b0;
		end else if (active) begin
			if (awaitN) begin
				// This half ends at the coming edge
				if (!wrN) begin
					word = readMem(wordAddr);
					if (lowHalf) word[15:0] = aDataOut;
					else word[31:16] = aDataOut;
					mem[wordAddr] = word;
				end
				if (!lowHalf) begin
					lowHalf = 1'b1;
					waitLeft = $urandom % 4;
					nextAwait = (waitLeft == 0);
					word = readMem(wordAddr);
					nextData = word[15:0];
				end else begin
					active = 1'b0;
				end
			end else begin
				waitLeft--;
				nextAwait = (waitLeft == 0);
			end
		end else if (!asN) begin
			active = 1'b1;
			lowHalf = 1'b0;
			wordAddr = aAddr[25:2];
			waitLeft = $urandom % 4;
			nextAwait = (waitLeft == 0);
			word = readMem(wordAddr);
			nextData = word[31:16];
		end
		@(posedge CLK);
		#1;
		awaitN = nextAwait;
		aDataIn = nextData;
	end
endmodule

// ==== tests/scu_assertions.sv ====
`timescale 1ns/1ps

module scuAssertions (
	input logic CLK,
	input logic RST_N,
	input logic pReady,
	input logic hostDone,
	input logic asN,
	input logic cs0N,
	input logic cs1N,
	input logic cs2N,
	input logic rdN,
	input logic wrN
);
	int   failCount = 0;
	logic anyCs;

	assign anyCs = !cs0N || !cs1N || !cs2N;

	strobeExclusive: assert property (@(posedge CLK) disable iff (!RST_N) !(!rdN && !wrN))
		else begin
			failCount++;
			$error("rdN and wrN low together");
		end

	csOneHot: assert property (@(posedge CLK) disable iff (!RST_N)
		$onehot0({!cs0N, !cs1N, !cs2N}))
		else begin
			failCount++;
			$error("more than one chip select low");
		end

	// Address strobe is a single cycle inside a selected access
	asWithCs: assert property (@(posedge CLK) disable iff (!RST_N) !asN |-> anyCs)
		else begin
			failCount++;
			$error("asN low without a chip select");
		end

	asOneCycle: assert property (@(posedge CLK) disable iff (!RST_N) !asN |=> asN)
		else begin
			failCount++;
			$error("asN low for more than one cycle");
		end

	strobeWithCs: assert property (@(posedge CLK) disable iff (!RST_N) (!rdN || !wrN) |-> anyCs)
		else begin
			failCount++;
			$error("data strobe without a chip select");
		end

	// Forwarded host access completes on APB the cycle after done
	readyAfterDone: assert property (@(posedge CLK) disable iff (!RST_N) hostDone |=> pReady)
		else begin
			failCount++;
			$error("pReady not high in the cycle after the host A-bus access ended");
		end
endmodule

// ==== tests/scuTb.sv ====
`timescale 1ns/1ps
`include "scu_cfg.svh"

module scuTb;
	localparam int APB_LIMIT = 200;
	localparam int POLL_LIMIT = 500;

	logic                   CLK;
	logic                   RST_N;
	logic                   pSel;
	logic                   pEnable;
	logic                   pWrite;
	logic [`SCU_ADDR_W-1:0] pAddr;
	logic [`SCU_DATA_W-1:0] pWData;
	logic [`SCU_DATA_W-1:0] pRData;
	logic                   pReady;
	logic                   pSlvErr;
	logic [`SCU_ADDR_W-2:0] aAddr;
	logic [`SCU_HALF_W-1:0] aDataOut;
	logic [`SCU_HALF_W-1:0] aDataIn;
	logic                   asN;
	logic                   cs0N;
	logic                   cs1N;
	logic                   cs2N;
	logic                   rdN;
	logic                   wrN;
	logic                   awaitN;
	logic                   vblankN;
	logic [3:0]             cirlN;

	// Word mirror of the A-bus memory keyed by address bits 25:2
	logic [31:0] model [logic [23:0]];
	int          checks;
	int          errors;
	int          timeouts;

	scuTop u_dut (
		.CLK(CLK), .RST_N(RST_N), .pSel(pSel), .pEnable(pEnable), .pWrite(pWrite),
		.pAddr(pAddr), .pWData(pWData), .pRData(pRData), .pReady(pReady), .pSlvErr(pSlvErr),
		.aAddr(aAddr), .aDataOut(aDataOut), .aDataIn(aDataIn), .asN(asN), .cs0N(cs0N),
		.cs1N(cs1N), .cs2N(cs2N), .rdN(rdN), .wrN(wrN), .awaitN(awaitN),
		.vblankN(vblankN), .cirlN(cirlN)
	);

	aBusMem uMem (
		.CLK(CLK), .RST_N(RST_N), .aAddr(aAddr), .aDataOut(aDataOut), .aDataIn(aDataIn),
		.asN(asN), .rdN(rdN), .wrN(wrN), .awaitN(awaitN)
	);

	bind scuTop scuAssertions uAssert (
		.CLK(CLK), .RST_N(RST_N), .pReady(pReady), .hostDone(hostBus.done),
		.asN(asN), .cs0N(cs0N), .cs1N(cs1N), .cs2N(cs2N), .rdN(rdN), .wrN(wrN)
	);

	always #4 CLK = ~CLK;

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL t=%0t %s: got %08h, expected %08h", $time, name, actual, expected);
		end
	endtask

	function automatic logic [26:0] regAddr(input logic [7:0] offset);
		return `SCU_REG_BASE + 27'(offset);
	endfunction

	function automatic logic [26:0] chanAddr(input int ch, input logic [7:0] offset);
		return regAddr(8'(ch * 32) + offset);
	endfunction

	function automatic logic [26:0] randomBusAddr(input logic [26:0] lo, input int span);
		return (lo + 27'($urandom % span)) & ~27'h3;
	endfunction

	// Highest unmasked source sets the level and cirlN is its inverse
	function automatic logic [3:0] expectedCirl(input logic [31:0] istat, input logic [31:0] mask);
		logic [31:0] active;
		logic [3:0]  level;
		active = istat & ~mask;
		if (active[0]) level = 4'hF;
		else if (active[11] || active[10]) level = 4'h6;
		else if (active[9]) level = 4'h5;
		else level = 4'h0;
		return ~level;
	endfunction

	// Inside the A-bus window bits 25:24 alone pick the chip select
	function automatic logic [2:0] expectedCs(input logic [25:0] a);
		if (a[25]) begin
			return 3'b011;
		end
		return a[24] ? 3'b110 : 3'b101;
	endfunction

	always @(negedge CLK) begin
		if (RST_N && !asN) begin
			checkValue("{cs0N,cs1N,cs2N}", 32'({cs0N, cs1N, cs2N}), 32'(expectedCs(aAddr)));
		end
	end

	task automatic apbAccess(input logic write, input logic [26:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata, output logic slvErr);
		int waitCount;
		@(posedge CLK);
		#1;
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = write;
		pAddr = addr;
		pWData = wdata;
		@(posedge CLK);
		#1;
		pEnable = 1'b1;
		waitCount = 0;
		@(negedge CLK);
		while (!pReady && waitCount < APB_LIMIT) begin
			waitCount++;
			@(negedge CLK);
		end
		if (!pReady) begin
			timeouts++;
			$display("Timeout: APB access to %07h got no pReady in %0d cycles", addr, APB_LIMIT);
		end
		rdata = pRData;
		slvErr = pSlvErr;
		@(posedge CLK);
		#1;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	task automatic writeWord(input logic [26:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        slvErr;
		apbAccess(1'b1, addr, data, rdata, slvErr);
		checkValue("pSlvErr", 32'(slvErr), 32'd0);
	endtask

	task automatic readWord(input logic [26:0] addr, output logic [31:0] data);
		logic slvErr;
		apbAccess(1'b0, addr, 32'd0, data, slvErr);
		checkValue("pSlvErr", 32'(slvErr), 32'd0);
	endtask

	task automatic hostWrite(input logic [26:0] addr, input logic [31:0] data);
		writeWord(addr, data);
		model[addr[25:2]] = data;
	endtask

	task automatic hostReadCheck(input logic [26:0] addr);
		logic [31:0] got;
		readWord(addr, got);
		checkValue($sformatf("pRData[%07h]", addr), got, model[addr[25:2]]);
	endtask

	task automatic testRegisters();
		logic [7:0]  offsets [5];
		logic [31:0] fieldMask [5];
		logic [31:0] data;
		logic [31:0] got;
		offsets = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10};
		fieldMask = '{32'h07FF_FFFF, 32'h07FF_FFFF, 32'h0000_0FFF, 32'h0000_0101, 32'h0000_0100};
		for (int c = 0; c < `SCU_DMA_CH; c++) begin
			for (int r = 0; r < 5; r++) begin
				data = $urandom;
				// GO stays clear here
				if (r == 4) data[0] = 1'b0;
				writeWord(chanAddr(c, offsets[r]), data);
				readWord(chanAddr(c, offsets[r]), got);
				checkValue($sformatf("ch%0d reg %02h", c, offsets[r]), got, data & fieldMask[r]);
			end
		end
		data = $urandom;
		writeWord(regAddr(8'hA0), data);
		readWord(regAddr(8'hA0), got);
		checkValue("mask", got, data & 32'h0000_0E01);
	endtask

	task automatic testHostBus();
		logic [26:0] addr;
		repeat (8) begin
			addr = randomBusAddr(`SCU_ABUS_LO, `SCU_ABUS_HI - `SCU_ABUS_LO + 1);
			hostWrite(addr, $urandom);
			hostReadCheck(addr);
		end
	endtask

	task automatic testUnmapped();
		logic [26:0] addr;
		logic [31:0] rdata;
		logic        slvErr;
		repeat (6) begin
			case ($urandom % 3)
				0: addr = 27'($urandom % `SCU_ABUS_LO);
				1: addr = `SCU_ABUS_HI + 27'd1 + 27'($urandom % (`SCU_REG_BASE - `SCU_ABUS_HI - 1));
				default: addr = `SCU_REG_BASE + `SCU_REG_LEN
					+ 27'($urandom % (32'h0800_0000 - (`SCU_REG_BASE + `SCU_REG_LEN)));
			endcase
			apbAccess(1'($urandom % 2), addr, $urandom, rdata, slvErr);
			checkValue($sformatf("pSlvErr[%07h]", addr), 32'(slvErr), 32'd1);
			checkValue($sformatf("pRData[%07h]", addr), rdata, 32'd0);
		end
	endtask

	task automatic runDmaCopy();
		int          ch;
		int          words;
		int          polls;
		logic        readInc;
		logic        writeInc;
		logic [26:0] srcBase;
		logic [26:0] dstBase;
		logic [26:0] ra;
		logic [26:0] wa;
		logic [31:0] mask;
		logic [31:0] status;
		logic [31:0] istat;
		logic [31:0] expIstat;
		ch = $urandom % `SCU_DMA_CH;
		words = 1 + $urandom % 16;
		readInc = 1'($urandom % 2);
		writeInc = 1'($urandom % 2);
		srcBase = randomBusAddr(27'h2000000, 32'h0100_0000);
		dstBase = randomBusAddr(27'h4000000, 32'h0100_0000);
		for (int i = 0; i < (readInc ? words : 1); i++) begin
			hostWrite(27'(srcBase + 4 * i), $urandom);
		end
		mask = $urandom & 32'h0000_0E01;
		writeWord(regAddr(8'hA0), mask);
		writeWord(chanAddr(ch, 8'h00), 32'(srcBase));
		writeWord(chanAddr(ch, 8'h04), 32'(dstBase));
		writeWord(chanAddr(ch, 8'h08), 32'(words));
		writeWord(chanAddr(ch, 8'h0C), {23'd0, readInc, 7'd0, writeInc});
		ra = srcBase;
		wa = dstBase;
		for (int i = 0; i < words; i++) begin
			model[wa[25:2]] = model[ra[25:2]];
			if (readInc) ra = ra + 27'd4;
			if (writeInc) wa = wa + 27'd4;
		end
		writeWord(chanAddr(ch, 8'h10), 32'h0000_0101);
		// Source reads compete with the copy for the A-bus
		polls = 0;
		readWord(regAddr(8'h7C), status);
		while ((status & 32'h77) != 0 && polls < POLL_LIMIT) begin
			hostReadCheck(27'(srcBase + 4 * ($urandom % (readInc ? words : 1))));
			readWord(regAddr(8'h7C), status);
			polls++;
		end
		if ((status & 32'h77) != 0) begin
			timeouts++;
			$display("Timeout: DMA channel %0d still busy after %0d polls", ch, polls);
		end
		for (int i = 0; i < (writeInc ? words : 1); i++) begin
			hostReadCheck(27'(dstBase + 4 * i));
		end
		expIstat = 32'h1 << (11 - ch);
		readWord(regAddr(8'hA4), istat);
		checkValue("istat after DMA", istat, expIstat);
		@(negedge CLK);
		checkValue("cirlN after DMA", 32'(cirlN), 32'(expectedCirl(expIstat, mask)));
		writeWord(regAddr(8'hA4), ~expIstat);
		@(posedge CLK);
		@(negedge CLK);
		checkValue("cirlN after clear", 32'(cirlN), 32'hF);
		readWord(regAddr(8'hA4), istat);
		checkValue("istat after clear", istat, 32'd0);
	endtask

	task automatic testVblank();
		logic [31:0] mask;
		logic [31:0] istat;
		mask = $urandom & 32'h0000_0E01;
		writeWord(regAddr(8'hA0), mask);
		@(posedge CLK);
		#1;
		vblankN = 1'b0;
		repeat (3) @(posedge CLK);
		#1;
		vblankN = 1'b1;
		readWord(regAddr(8'hA4), istat);
		checkValue("istat after vblank", istat, 32'h1);
		@(negedge CLK);
		checkValue("cirlN after vblank", 32'(cirlN), 32'(expectedCirl(32'h1, mask)));
		writeWord(regAddr(8'hA4), 32'hFFFF_FFFE);
		@(posedge CLK);
		@(negedge CLK);
		checkValue("cirlN after vblank clear", 32'(cirlN), 32'hF);
		readWord(regAddr(8'hA4), istat);
		checkValue("istat after vblank clear", istat, 32'd0);
	endtask

	initial begin
		void'($urandom(71486));
		checks = 0;
		errors = 0;
		timeouts = 0;
		CLK = 1'b0;
		RST_N = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		vblankN = 1'b1;
		repeat (3) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		@(negedge CLK);
		checkValue("cirlN after reset", 32'(cirlN), 32'hF);
		checkValue("pReady after reset", 32'(pReady), 32'd0);
		checkValue("strobes after reset", 32'({asN, cs0N, cs1N, cs2N, rdN, wrN}), 32'h3F);
		testRegisters();
		testHostBus();
		testUnmapped();
		repeat (6) runDmaCopy();
		repeat (4) testVblank();
		repeat (4) @(posedge CLK);
		$display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, u_dut.uAssert.failCount);
		if (errors == 0 && timeouts == 0 && u_dut.uAssert.failCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end
endmodule

// ==== sources.f ====
+incdir+verilog
verilog/scuPkg.sv
verilog/aBusReqIf.sv
verilog/cpuPort.sv
verilog/dmaEngine.sv
verilog/aBusArbiter.sv
verilog/aBusMaster.sv
verilog/scuTop.sv
tests/aBusMem.sv
tests/scu_assertions.sv
tests/scuTb.sv

// ==== Bender.yml ====
package:
  name: scu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/scuPkg.sv
      - verilog/aBusReqIf.sv
      - verilog/cpuPort.sv
      - verilog/dmaEngine.sv
      - verilog/aBusArbiter.sv
      - verilog/aBusMaster.sv
      - verilog/scuTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/aBusMem.sv
      - tests/scu_assertions.sv
      - tests/scuTb.sv
